//--- Makefile
# Verilator flow for the dual-clock FIFO
VERILATOR ?= verilator
TOP       ?= async_fifo_tb
RTL_TOP   ?= async_fifo
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/async_fifo_tb.sv
`default_nettype none

module async_fifo_tb;

  localparam int DATA_W   = 8;
  localparam int DEPTH    = 16;
  localparam int AFULL_TH = 12;
  localparam int AEMPTY_TH = 3;
  localparam int GUARD    = 200;

  logic              wr_clk;
  logic              wr_rst_n;
  logic              wr_en;
  logic [DATA_W-1:0] wr_data;
  logic              rd_clk;
  logic              rd_rst_n;
  logic              rd_en;
  logic [DATA_W-1:0] rd_data;
  logic              full;
  logic              afull;
  logic              empty;
  logic              aempty;

  logic [DATA_W-1:0] model_q[$];
  logic [DATA_W-1:0] rd_expect;
  logic [DATA_W-1:0] last_word;
  logic              rd_pending;
  logic              traffic_on;
  int                wr_accepts;
  int                rd_accepts;
  int                check_count;
  int                error_count;
  int                timeout_count;
  int                edge_lvls[6] = '{16, 12, 11, 4, 3, 0};

  async_fifo #(
    .DATA_WIDTH  (DATA_W),
    .FIFO_DEPTH  (DEPTH),
    .FIFO_AFULL  (AFULL_TH),
    .FIFO_AEMPTY (AEMPTY_TH)
  ) u_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  always #50 wr_clk = ~wr_clk;
  always #35 rd_clk = ~rd_clk;

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("error at %0t: timed out waiting for %s", $time, what);
  endtask

  // Model updates on the accepting edges
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      model_q.push_back(wr_data);
      wr_accepts++;
    end
  end

  always @(posedge rd_clk) begin
    if (rd_pending) begin
      check_value(32'(rd_data), 32'(rd_expect), "read data");
      rd_pending = 1'b0;
    end
    if (rd_rst_n && rd_en && !empty) begin
      rd_accepts++;
      if (model_q.size() == 0) begin
        error_count++;
        $display("error at %0t: read accepted while the model holds no data", $time);
      end else begin
        rd_expect  = model_q.pop_front();
        last_word  = rd_expect;
        rd_pending = 1'b1;
      end
    end
  end

  // Lets both synchronizers catch up
  task automatic settle();
    repeat (5) @(posedge wr_clk);
    repeat (5) @(posedge rd_clk);
  endtask

  task automatic random_traffic(input int cycles);
    int unsigned wr_rate;
    int unsigned rd_rate;
    int          guard;
    traffic_on = 1'b1;
    fork
      begin
        for (int i = 0; i < cycles; i++) begin
          @(negedge wr_clk);
          if (i % 100 == 0) wr_rate = $urandom_range(10, 1);
          wr_en   = ($urandom_range(9, 0) < wr_rate);
          wr_data = DATA_W'($urandom);
        end
        @(negedge wr_clk);
        wr_en      = 1'b0;
        traffic_on = 1'b0;
      end
      begin
        guard = 0;
        while (traffic_on && guard < 4 * cycles) begin
          @(negedge rd_clk);
          if (guard % 70 == 0) rd_rate = $urandom_range(10, 1);
          rd_en = ($urandom_range(9, 0) < rd_rate);
          guard++;
        end
        rd_en = 1'b0;
        if (guard >= 4 * cycles) report_timeout("the end of random traffic");
      end
    join
  endtask

  task automatic drain_to_empty();
    int start_reads;
    int expect_reads;
    int guard;
    settle();
    start_reads  = rd_accepts;
    expect_reads = model_q.size();
    guard        = 0;
    @(negedge rd_clk);
    while (!empty && guard < GUARD) begin
      rd_en = 1'b1;
      @(negedge rd_clk);
      guard++;
    end
    rd_en = 1'b0;
    if (guard >= GUARD) report_timeout("empty during drain");
    check_value(32'(rd_accepts - start_reads), 32'(expect_reads), "words read in drain");
    check_value(32'(model_q.size()), 32'd0, "model count after drain");
  endtask

  task automatic idle_read_pulses();
    int start_reads;
    start_reads = rd_accepts;
    repeat (4) begin
      @(negedge rd_clk);
      rd_en = 1'b1;
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
    check_value(32'(rd_accepts - start_reads), 32'd0, "reads accepted while empty");
    check_value(32'(rd_data), 32'(last_word), "rd_data hold while empty");
  endtask

  task automatic fill_to_full();
    int start_writes;
    int guard;
    settle();
    start_writes = wr_accepts;
    guard        = 0;
    @(negedge wr_clk);
    while (!full && guard < GUARD) begin
      wr_en   = 1'b1;
      wr_data = DATA_W'($urandom);
      @(negedge wr_clk);
      guard++;
    end
    if (guard >= GUARD) report_timeout("full during fill");
    check_value(32'(wr_accepts - start_writes), 32'(DEPTH), "writes accepted until full");
    // Keep pushing against full
    repeat (4) begin
      wr_data = DATA_W'($urandom);
      @(negedge wr_clk);
    end
    wr_en = 1'b0;
    check_value(32'(full), 32'd1, "full held while pushing");
    check_value(32'(model_q.size()), 32'(DEPTH), "model count after writes while full");
  endtask

  task automatic move_to_level(input int target);
    int guard;
    guard = 0;
    @(negedge wr_clk);
    while (model_q.size() < target && guard < GUARD) begin
      wr_en   = 1'b1;
      wr_data = DATA_W'($urandom);
      @(negedge wr_clk);
      guard++;
    end
    wr_en = 1'b0;
    @(negedge rd_clk);
    while (model_q.size() > target && guard < GUARD) begin
      rd_en = 1'b1;
      @(negedge rd_clk);
      guard++;
    end
    rd_en = 1'b0;
    if (guard >= GUARD) report_timeout($sformatf("fill level %0d", target));
  endtask

  task automatic check_flags();
    int n;
    settle();
    n = model_q.size();
    @(negedge wr_clk);
    check_value(32'(full), 32'(n == DEPTH), $sformatf("full at level %0d", n));
    check_value(32'(afull), 32'(n >= AFULL_TH), $sformatf("afull at level %0d", n));
    @(negedge rd_clk);
    check_value(32'(empty), 32'(n == 0), $sformatf("empty at level %0d", n));
    check_value(32'(aempty), 32'(n <= AEMPTY_TH), $sformatf("aempty at level %0d", n));
  endtask

  initial begin
    void'($urandom(32'h13f3));
    wr_clk        = 1'b0;
    rd_clk        = 1'b0;
    wr_rst_n      = 1'b0;
    rd_rst_n      = 1'b0;
    wr_en         = 1'b0;
    wr_data       = '0;
    rd_en         = 1'b0;
    rd_pending    = 1'b0;
    last_word     = '0;
    rd_expect     = '0;
    wr_accepts    = 0;
    rd_accepts    = 0;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    repeat (3) @(posedge wr_clk);
    @(negedge wr_clk);
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    @(negedge wr_clk);
    check_value(32'(full), 32'd0, "full after reset");
    check_value(32'(afull), 32'd0, "afull after reset");
    check_value(32'(empty), 32'd1, "empty after reset");
    check_value(32'(aempty), 32'd1, "aempty after reset");

    random_traffic(2000);
    drain_to_empty();
    idle_read_pulses();
    fill_to_full();
    drain_to_empty();

    for (int t = 0; t < 16; t++) begin
      move_to_level((t < 6) ? edge_lvls[t] : int'($urandom_range(DEPTH, 0)));
      check_flags();
    end
    drain_to_empty();
    settle();

    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/afifo_mem_if.sv
`default_nettype none

interface afifo_mem_if #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
);

  // Write port, wr_clk domain
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;

  // Read port, rd_clk domain
  logic                  rd_en;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [DATA_WIDTH-1:0] rd_data;

  // Data is fed in by the top level
  modport wr_side (
    output wr_en,
    output wr_addr
  );

  modport rd_side (
    output rd_en,
    output rd_addr,
    input  rd_data
  );

  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

//--- source/afifo_pkg.sv
`default_nettype none

package afifo_pkg;

  localparam int MAX_ADDR_WIDTH = 8;

  // Occupancy and threshold values
  typedef logic [MAX_ADDR_WIDTH:0] level_t;

  localparam int DEF_DATA_WIDTH  = 8;
  localparam int DEF_FIFO_DEPTH  = 16;
  localparam int DEF_FIFO_AFULL  = DEF_FIFO_DEPTH - 1;
  localparam int DEF_FIFO_AEMPTY = 1;

  // Ones over the pointer bits, wrap bit included
  function automatic level_t ptr_mask(input int unsigned width);
    return (level_t'(1) << (width + 1)) - level_t'(1);
  endfunction

  function automatic level_t bin2gray(input level_t bin, input int unsigned width);
    level_t b;
    b = bin & ptr_mask(width);
    return (b >> 1) ^ b;
  endfunction

  function automatic level_t gray2bin(input level_t gray, input int unsigned width);
    level_t g;
    level_t bin;
    g = gray & ptr_mask(width);
    bin[MAX_ADDR_WIDTH] = g[MAX_ADDR_WIDTH];
    for (int i = MAX_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ g[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

//--- source/afifo_ram.sv
`default_nettype none

module afifo_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input logic            wr_clk,
  input logic            rd_clk,
  input logic            rd_rst_n,
  afifo_mem_if.mem       mem
);

  localparam int WORDS = 2 ** ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] words [WORDS];
  logic [DATA_WIDTH-1:0] rd_q;

  always_ff @(posedge wr_clk) begin
    if (mem.wr_en) begin
      words[mem.wr_addr] <= mem.wr_data;
    end
  end

  // Holds the last word until the next accepted read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_q <= '0;
    end else if (mem.rd_en) begin
      rd_q <= words[mem.rd_addr];
    end
  end

  assign mem.rd_data = rd_q;

endmodule

`default_nettype wire

//--- source/afifo_rd_ctrl.sv
`default_nettype none

module afifo_rd_ctrl import afifo_pkg::*; #(
  parameter int ADDR_WIDTH  = $clog2(DEF_FIFO_DEPTH),
  parameter int FIFO_AEMPTY = DEF_FIFO_AEMPTY
) (
  input  logic              rd_clk,
  input  logic              rd_rst_n,
  input  logic              rd_en,
  input  logic [ADDR_WIDTH:0] wr_gray,
  output logic [ADDR_WIDTH:0] rd_gray,
  output logic              empty,
  output logic              aempty,
  afifo_mem_if.rd_side      mem
);

  localparam level_t AEMPTY_LVL = level_t'(FIFO_AEMPTY);

  logic [ADDR_WIDTH:0] rd_bin;
  logic [ADDR_WIDTH:0] rd_bin_nxt;
  logic [ADDR_WIDTH:0] rd_gray_nxt;
  logic [ADDR_WIDTH:0] wr_gray_s1;
  logic [ADDR_WIDTH:0] wr_gray_s2;
  logic [ADDR_WIDTH:0] wr_bin_sync;
  logic [ADDR_WIDTH:0] diff_nxt;
  logic                rd_acc;
  level_t              rd_gray_lvl;
  level_t              wr_bin_lvl;
  level_t              used_nxt;

  assign rd_acc     = rd_en & ~empty;
  assign rd_bin_nxt = rd_bin + {{ADDR_WIDTH{1'b0}}, rd_acc};

  assign rd_gray_lvl = bin2gray(level_t'(rd_bin_nxt), ADDR_WIDTH);
  assign rd_gray_nxt = rd_gray_lvl[ADDR_WIDTH:0];

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // Write pointer into the read domain
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign wr_bin_lvl  = gray2bin(level_t'(wr_gray_s2), ADDR_WIDTH);
  assign wr_bin_sync = wr_bin_lvl[ADDR_WIDTH:0];

  assign diff_nxt = wr_bin_sync - rd_bin_nxt;
  assign used_nxt = level_t'(diff_nxt);

  // Empty after reset, until a write has crossed over
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (used_nxt == '0);
      aempty <= (used_nxt <= AEMPTY_LVL);
    end
  end

  assign mem.rd_en   = rd_acc;
  assign mem.rd_addr = rd_bin[ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

//--- source/afifo_wr_ctrl.sv
`default_nettype none

module afifo_wr_ctrl import afifo_pkg::*; #(
  parameter int ADDR_WIDTH = $clog2(DEF_FIFO_DEPTH),
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH,
  parameter int FIFO_AFULL = DEF_FIFO_AFULL
) (
  input  logic              wr_clk,
  input  logic              wr_rst_n,
  input  logic              wr_en,
  input  logic [ADDR_WIDTH:0] rd_gray,
  output logic [ADDR_WIDTH:0] wr_gray,
  output logic              full,
  output logic              afull,
  afifo_mem_if.wr_side      mem
);

  localparam level_t DEPTH_LVL = level_t'(FIFO_DEPTH);
  localparam level_t AFULL_LVL = level_t'(FIFO_AFULL);

  logic [ADDR_WIDTH:0] wr_bin;
  logic [ADDR_WIDTH:0] wr_bin_nxt;
  logic [ADDR_WIDTH:0] wr_gray_nxt;
  logic [ADDR_WIDTH:0] rd_gray_s1;
  logic [ADDR_WIDTH:0] rd_gray_s2;
  logic [ADDR_WIDTH:0] rd_bin_sync;
  logic [ADDR_WIDTH:0] diff_nxt;
  logic                wr_acc;
  level_t              wr_gray_lvl;
  level_t              rd_bin_lvl;
  level_t              used_nxt;

  assign wr_acc     = wr_en & ~full;
  assign wr_bin_nxt = wr_bin + {{ADDR_WIDTH{1'b0}}, wr_acc};

  assign wr_gray_lvl = bin2gray(level_t'(wr_bin_nxt), ADDR_WIDTH);
  assign wr_gray_nxt = wr_gray_lvl[ADDR_WIDTH:0];

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
    end
  end

  // Read pointer into the write domain
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  assign rd_bin_lvl  = gray2bin(level_t'(rd_gray_s2), ADDR_WIDTH);
  assign rd_bin_sync = rd_bin_lvl[ADDR_WIDTH:0];

  // Wraps at ADDR_WIDTH+1 bits before widening
  assign diff_nxt = wr_bin_nxt - rd_bin_sync;
  assign used_nxt = level_t'(diff_nxt);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (used_nxt == DEPTH_LVL);
      afull <= (used_nxt >= AFULL_LVL);
    end
  end

  assign mem.wr_en   = wr_acc;
  assign mem.wr_addr = wr_bin[ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

//--- source/async_fifo.sv
`default_nettype none

module async_fifo import afifo_pkg::*; #(
  parameter int DATA_WIDTH  = DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH  = DEF_FIFO_DEPTH,
  parameter int FIFO_AFULL  = DEF_FIFO_AFULL,
  parameter int FIFO_AEMPTY = DEF_FIFO_AEMPTY
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  full,
  output logic                  afull,
  output logic                  empty,
  output logic                  aempty
);

  // Depth is a power of two, 4 to 256
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic [ADDR_WIDTH:0] wr_gray;
  logic [ADDR_WIDTH:0] rd_gray;

  afifo_mem_if #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) mem_if ();

  assign mem_if.wr_data = wr_data;
  assign rd_data        = mem_if.rd_data;

  afifo_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ram (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .mem      (mem_if.mem)
  );

  afifo_wr_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) u_wr_ctrl (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .rd_gray  (rd_gray),
    .wr_gray  (wr_gray),
    .full     (full),
    .afull    (afull),
    .mem      (mem_if.wr_side)
  );

  afifo_rd_ctrl #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) u_rd_ctrl (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .wr_gray  (wr_gray),
    .rd_gray  (rd_gray),
    .empty    (empty),
    .aempty   (aempty),
    .mem      (mem_if.rd_side)
  );

endmodule

`default_nettype wire

//--- vlog.f
source/afifo_pkg.sv
source/afifo_mem_if.sv
source/afifo_ram.sv
source/afifo_wr_ctrl.sv
source/afifo_rd_ctrl.sv
source/async_fifo.sv
bench/async_fifo_tb.sv
